// File: amber_wb_master.f
+incdir+hw
hw/wb_bus_pkg.sv
hw/core_req_pkg.sv
hw/core_req_hold.sv
hw/wb_sequencer.sv
hw/amber_wb_master.sv
tb/wb_mem_model.sv
tb/tb_amber_wb_master.sv

// File: hw/amber_wb_config.svh
// width and burst-length macros for the wishbone master, pulled in with `include by each user

`ifndef AMBER_WB_CONFIG_SVH
`define AMBER_WB_CONFIG_SVH

// ========================================
// bus widths
// ========================================

// byte address width on the wishbone bus
`define AWB_ADDR_W 32

// data word width, one word per ack
`define AWB_DATA_W 32

// one select bit per byte lane of a data word
`define AWB_SEL_W 4

// ========================================
// cache line
// ========================================

// words per cache-line burst, the burst wraps inside one line
`define AWB_BURST_LEN 4

`endif

// File: hw/amber_wb_master.sv
// top level of the wishbone master, connects the two cache request holders to the bus sequencer

`timescale 1ns/1ps

`include "amber_wb_config.svh"

module amber_wb_master
    import wb_bus_pkg::*, core_req_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   quick_n_reset,
    input  logic                   i_icache_req,
    input  icache_req_t            i_icache,
    output logic                   o_icache_ready,
    output logic [`AWB_DATA_W-1:0] o_icache_rdata,
    input  logic                   i_dcache_req,
    input  dcache_req_t            i_dcache,
    output logic                   o_dcache_ready,
    output logic [`AWB_DATA_W-1:0] o_dcache_rdata,
    output wb_m2s_t                o_wb,
    input  wb_s2m_t                i_wb
);

    // held request from each cache and the matching completion from the sequencer
    logic                   ipend;
    icache_req_t            ireq_q;
    logic                   idone;
    logic                   dpend;
    dcache_req_t            dreq_q;
    logic                   ddone;
    logic [`AWB_DATA_W-1:0] rdata;

    // ========================================
    // request holders
    // ========================================

    core_req_hold #(.T(icache_req_t)) u_ihold (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_req         (i_icache_req),
        .i_payload     (i_icache),
        .i_done        (idone),
        .o_pending     (ipend),
        .o_payload     (ireq_q)
    );

    core_req_hold #(.T(dcache_req_t)) u_dhold (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_req         (i_dcache_req),
        .i_payload     (i_dcache),
        .i_done        (ddone),
        .o_pending     (dpend),
        .o_payload     (dreq_q)
    );

    // ========================================
    // bus sequencer
    // ========================================

    wb_sequencer u_seq (
        .i_clk          (i_clk),
        .quick_n_reset  (quick_n_reset),
        .i_ipend        (ipend),
        .i_ireq         (ireq_q),
        .i_dpend        (dpend),
        .i_dreq         (dreq_q),
        .o_idone        (idone),
        .o_ddone        (ddone),
        .o_icache_ready (o_icache_ready),
        .o_dcache_ready (o_dcache_ready),
        .o_rdata        (rdata),
        .o_wb           (o_wb),
        .i_wb           (i_wb)
    );

    // both caches see the bus data, their ready pulse says whose word it is
    assign o_icache_rdata = rdata;
    assign o_dcache_rdata = rdata;

endmodule

// File: hw/core_req_hold.sv
// holds one cache request pending until the bus master finishes it, instantiated once per cache

`timescale 1ns/1ps

module core_req_hold
#(
    parameter type T = logic
)
(
    input  logic i_clk,
    input  logic quick_n_reset,
    input  logic i_req,
    input  T     i_payload,
    input  logic i_done,
    output logic o_pending,
    output T     o_payload
);

    // the strobe only lasts one cycle so the request must be kept here
    logic pending_r;
    T     payload_r;

    // ========================================
    // pending flag
    // ========================================

    // a new strobe wins over done so a request issued in the final-ack cycle is not lost
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            pending_r <= 1'b0;
        end
        else if (i_req)
        begin
            pending_r <= 1'b1;
        end
        else if (i_done)
        begin
            pending_r <= 1'b0;
        end
    end

    // ========================================
    // payload
    // ========================================

    // payload is captured with the strobe and stays put while the bus works on it
    always_ff @(posedge i_clk)
    begin
        if (i_req)
        begin
            payload_r <= i_payload;
        end
    end

    assign o_pending = pending_r;
    assign o_payload = payload_r;

    // a requester waits for its last ready pulse before it strobes again
    // the only overlap allowed is a strobe in the very cycle the sequencer finishes
    a_no_overlap: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_req && pending_r) |-> i_done);

endmodule

// File: hw/core_req_pkg.sv
// packed structs for the instruction and data cache requests, imported by the master and its testbench

`include "amber_wb_config.svh"

package core_req_pkg;

    // ========================================
    // instruction cache
    // ========================================

    // the instruction cache only ever reads
    // qword asks for a full line burst that starts at the addressed word
    typedef struct packed {
        logic [`AWB_ADDR_W-1:0] addr;
        logic                   qword;
    } icache_req_t;

    // ========================================
    // data cache
    // ========================================

    // one request format covers single reads, line fills and writes
    // qword is only honoured when write is low
    // be carries the byte enables of a write and is ignored for reads
    typedef struct packed {
        logic [`AWB_ADDR_W-1:0] addr;
        logic                   qword;
        logic                   write;
        logic [`AWB_DATA_W-1:0] wdata;
        logic [`AWB_SEL_W-1:0]  be;
    } dcache_req_t;

    // the two formats share the address field at the top of the struct
    // so a request can be routed by looking only at pending and the payload

endpackage

// File: hw/wb_bus_pkg.sv
// packed structs for both directions of the wishbone bus, imported by the master and its testbench

`include "amber_wb_config.svh"

package wb_bus_pkg;

    // ========================================
    // master to slave
    // ========================================

    // everything the master drives onto the bus
    // adr, sel, we and dat must hold still while stb waits for ack
    typedef struct packed {
        logic [`AWB_ADDR_W-1:0] adr;
        logic [`AWB_SEL_W-1:0]  sel;
        logic                   we;
        logic [`AWB_DATA_W-1:0] dat;
        logic                   cyc;
        logic                   stb;
    } wb_m2s_t;

    // ========================================
    // slave to master
    // ========================================

    // read data comes back in the same cycle as its ack
    // every cycle with ack high completes exactly one word
    typedef struct packed {
        logic [`AWB_DATA_W-1:0] dat;
        logic                   ack;
    } wb_s2m_t;

endpackage

// File: hw/wb_sequencer.sv
// arbitrates the two held cache requests and runs them as wishbone single or burst cycles

`timescale 1ns/1ps

`include "amber_wb_config.svh"

module wb_sequencer
    import wb_bus_pkg::*, core_req_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   quick_n_reset,
    input  logic                   i_ipend,
    input  icache_req_t            i_ireq,
    input  logic                   i_dpend,
    input  dcache_req_t            i_dreq,
    output logic                   o_idone,
    output logic                   o_ddone,
    output logic                   o_icache_ready,
    output logic                   o_dcache_ready,
    output logic [`AWB_DATA_W-1:0] o_rdata,
    output wb_m2s_t                o_wb,
    input  wb_s2m_t                i_wb
);

    // byte offset bits inside a word and word index bits inside a line
    localparam int WOFF_W = $clog2(`AWB_SEL_W);
    localparam int BIDX_W = $clog2(`AWB_BURST_LEN);

    // burst1..3 each wait for one ack, wait_ack waits for the last one
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_BURST1,
        ST_BURST2,
        ST_BURST3,
        ST_WAIT_ACK
    } wb_state_e;

    wb_state_e              state_r;
    // high while the data cache owns the current access
    logic                   serve_d_r;
    logic                   stb_r;
    logic                   we_r;
    logic [`AWB_ADDR_W-1:0] adr_r;
    logic [`AWB_SEL_W-1:0]  sel_r;
    logic [`AWB_DATA_W-1:0] dat_r;

    logic                   ack_c;
    logic                   start_c;
    logic                   pick_d_c;
    logic                   dquad_c;
    logic                   iquad_c;
    logic                   step_c;
    logic                   final_c;

    // the address low bits point at the first enabled lane for byte and halfword writes
    // every other pattern is sent word aligned
    function automatic logic [WOFF_W-1:0] lane_offset(input logic [`AWB_SEL_W-1:0] be);
        logic [WOFF_W-1:0] off;
        begin
            off = '0;
            case (be)
                4'b0001: off = 2'd0;
                4'b0010: off = 2'd1;
                4'b0100: off = 2'd2;
                4'b1000: off = 2'd3;
                4'b0011: off = 2'd0;
                4'b1100: off = 2'd2;
                default: off = 2'd0;
            endcase
            return off;
        end
    endfunction

    // ========================================
    // decode
    // ========================================

    // an ack only counts while we are actually strobing
    assign ack_c    = stb_r && i_wb.ack;
    assign start_c  = (state_r == ST_IDLE) && (i_dpend || i_ipend);
    // data cache has priority whenever both are waiting
    assign pick_d_c = i_dpend;
    assign dquad_c  = i_dreq.qword && !i_dreq.write;
    assign iquad_c  = i_ireq.qword;
    // the first three beats of a line fill move the word index on
    assign step_c   = ack_c && ((state_r == ST_BURST1) || (state_r == ST_BURST2) ||
                                (state_r == ST_BURST3));
    assign final_c  = (state_r == ST_WAIT_ACK) && ack_c;

    // ========================================
    // control FSM
    // ========================================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state_r   <= ST_IDLE;
            serve_d_r <= 1'b0;
            stb_r     <= 1'b0;
            we_r      <= 1'b0;
        end
        else
        begin
            case (state_r)
                ST_IDLE:
                begin
                    if (start_c)
                    begin
                        stb_r     <= 1'b1;
                        serve_d_r <= pick_d_c;
                        if (pick_d_c)
                        begin
                            we_r    <= i_dreq.write;
                            state_r <= dquad_c ? ST_BURST1 : ST_WAIT_ACK;
                        end
                        else
                        begin
                            we_r    <= 1'b0;
                            state_r <= iquad_c ? ST_BURST1 : ST_WAIT_ACK;
                        end
                    end
                end
                ST_BURST1:
                begin
                    if (ack_c)
                    begin
                        state_r <= ST_BURST2;
                    end
                end
                ST_BURST2:
                begin
                    if (ack_c)
                    begin
                        state_r <= ST_BURST3;
                    end
                end
                ST_BURST3:
                begin
                    if (ack_c)
                    begin
                        state_r <= ST_WAIT_ACK;
                    end
                end
                ST_WAIT_ACK:
                begin
                    // the bus always drops for a cycle between accesses
                    if (ack_c)
                    begin
                        state_r <= ST_IDLE;
                        stb_r   <= 1'b0;
                        we_r    <= 1'b0;
                    end
                end
                default:
                begin
                    state_r <= ST_IDLE;
                end
            endcase
        end
    end

    // ========================================
    // address, select and write data
    // ========================================

    always_ff @(posedge i_clk)
    begin
        if (start_c && pick_d_c)
        begin
            adr_r[`AWB_ADDR_W-1:WOFF_W] <= i_dreq.addr[`AWB_ADDR_W-1:WOFF_W];
            adr_r[WOFF_W-1:0]           <= i_dreq.write ? lane_offset(i_dreq.be) : '0;
            sel_r                       <= i_dreq.write ? i_dreq.be : '1;
            dat_r                       <= i_dreq.wdata;
        end
        else if (start_c)
        begin
            // instruction fetches are always full aligned words
            adr_r[`AWB_ADDR_W-1:WOFF_W] <= i_ireq.addr[`AWB_ADDR_W-1:WOFF_W];
            adr_r[WOFF_W-1:0]           <= '0;
            sel_r                       <= '1;
        end
        else if (step_c)
        begin
            // the word index wraps so the fill stays inside its line
            adr_r[WOFF_W +: BIDX_W] <= adr_r[WOFF_W +: BIDX_W] + BIDX_W'(1);
        end
    end

    // ========================================
    // outputs
    // ========================================

    always_comb
    begin
        o_wb.adr = adr_r;
        o_wb.sel = sel_r;
        o_wb.we  = we_r;
        o_wb.dat = dat_r;
        // cyc covers the whole access from the first strobe to the final ack
        o_wb.cyc = (state_r != ST_IDLE);
        o_wb.stb = stb_r;
    end

    // ready follows every ack of the owner, done only the last one
    assign o_icache_ready = ack_c && !serve_d_r;
    assign o_dcache_ready = ack_c && serve_d_r;
    assign o_idone        = final_c && !serve_d_r;
    assign o_ddone        = final_c && serve_d_r;
    assign o_rdata        = i_wb.dat;

    // a line fill takes one step per ack, keeps stb up and moves the word index on by one
    a_burst1: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_r == ST_BURST1 && ack_c) |=>
            (state_r == ST_BURST2) && o_wb.stb &&
            (o_wb.adr[WOFF_W +: BIDX_W] == $past(o_wb.adr[WOFF_W +: BIDX_W]) + BIDX_W'(1)));
    a_burst2: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_r == ST_BURST2 && ack_c) |=>
            (state_r == ST_BURST3) && o_wb.stb &&
            (o_wb.adr[WOFF_W +: BIDX_W] == $past(o_wb.adr[WOFF_W +: BIDX_W]) + BIDX_W'(1)));
    a_burst3: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_r == ST_BURST3 && ack_c) |=>
            (state_r == ST_WAIT_ACK) && o_wb.stb &&
            (o_wb.adr[WOFF_W +: BIDX_W] == $past(o_wb.adr[WOFF_W +: BIDX_W]) + BIDX_W'(1)));

    a_stb_cyc: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        o_wb.stb |-> o_wb.cyc);

    // the slave may stall for any number of cycles and must see the same beat throughout
    a_hold: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (o_wb.stb && !i_wb.ack) |=> $stable({o_wb.adr, o_wb.sel, o_wb.we, o_wb.dat}));

endmodule

// File: run_sim.sh
#!/bin/sh
# builds the wishbone master testbench with verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_amber_wb_master -f amber_wb_master.f -o sim_tb
./obj_dir/sim_tb

// File: tb/tb_amber_wb_master.sv
// testbench for the wishbone master, runs directed and random cache requests against a memory model

`timescale 1ns/1ps

`include "amber_wb_config.svh"

module tb_amber_wb_master
    import wb_bus_pkg::*, core_req_pkg::*;
();

    localparam int N_SINGLE  = 4;
    localparam int N_QUAD    = 8;
    localparam int N_WRITE   = 8;
    localparam int N_DUAL    = 2;
    localparam int N_RANDOM  = 40;
    // each write is followed by a read, and a dual step or random step may hold two requests
    localparam int NUM_TESTS = N_SINGLE + N_QUAD + 2*N_WRITE + 2*N_DUAL + 2*N_RANDOM;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 4 * 6 + NUM_TESTS * 8 + 200;

    // one expected bus beat, queued in the order the bus has to run them
    typedef struct packed {
        logic [`AWB_ADDR_W-1:0] adr;
        logic [`AWB_SEL_W-1:0]  sel;
        logic                   we;
        logic [`AWB_DATA_W-1:0] dat;
        logic                   is_d;
        logic                   last;
    } beat_t;

    logic                   clk;
    logic                   quick_n_reset;
    logic                   icache_req;
    icache_req_t            icache;
    logic                   icache_ready;
    logic [`AWB_DATA_W-1:0] icache_rdata;
    logic                   dcache_req;
    dcache_req_t            dcache;
    logic                   dcache_ready;
    logic [`AWB_DATA_W-1:0] dcache_rdata;
    wb_m2s_t                wb_m2s;
    wb_s2m_t                wb_s2m;

    beat_t                  exp_q [$];
    beat_t                  beat;
    logic [`AWB_DATA_W-1:0] ref_mem [0:255];
    logic                   started;
    logic                   idle_chk;
    logic [3:0]             be_list [0:7];

    amber_wb_master dut (
        .i_clk          (clk),
        .quick_n_reset  (quick_n_reset),
        .i_icache_req   (icache_req),
        .i_icache       (icache),
        .o_icache_ready (icache_ready),
        .o_icache_rdata (icache_rdata),
        .i_dcache_req   (dcache_req),
        .i_dcache       (dcache),
        .o_dcache_ready (dcache_ready),
        .o_dcache_rdata (dcache_rdata),
        .o_wb           (wb_m2s),
        .i_wb           (wb_s2m)
    );

    wb_mem_model u_mem (
        .i_clk         (clk),
        .quick_n_reset (quick_n_reset),
        .i_wb          (wb_m2s),
        .o_wb          (wb_s2m)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================
    // failure reporting and helpers
    // ========================================

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_run($sformatf("** Error at %0d ns: %s is 0x%h, expected 0x%h",
                           $time, name, got, exp));
    endtask

    // same word pattern the memory model loads at reset
    function automatic logic [31:0] fill_word(input int idx);
        return (32'(idx) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    // byte writes and the two aligned halfwords point at their lowest lane, all else is aligned
    function automatic logic [1:0] expected_offset(input logic [3:0] be);
        logic [1:0] lowest;
        lowest = 2'd0;
        for (int k = 3; k >= 0; k--)
        begin
            if (be[k])
            begin
                lowest = 2'(k);
            end
        end
        if ($countones(be) == 1 || be == 4'b0011 || be == 4'b1100)
        begin
            return lowest;
        end
        return 2'd0;
    endfunction

    function automatic icache_req_t mk_ireq(input logic [31:0] addr, input logic quad);
        icache_req_t r;
        r.addr  = addr;
        r.qword = quad;
        return r;
    endfunction

    function automatic dcache_req_t mk_dreq(input logic [31:0] addr, input logic quad,
                                            input logic wr, input logic [31:0] wdata,
                                            input logic [3:0] be);
        dcache_req_t r;
        r.addr  = addr;
        r.qword = quad;
        r.write = wr;
        r.wdata = wdata;
        r.be    = be;
        return r;
    endfunction

    // reads are word aligned with all lanes, a line fill wraps bits 3:2 from the start word
    task automatic push_read(input logic is_d, input logic [31:0] addr, input logic quad);
        beat_t b;
        for (int k = 0; k < (quad ? `AWB_BURST_LEN : 1); k++)
        begin
            b.adr  = {addr[31:4], 2'(addr[3:2] + 2'(k)), 2'b00};
            b.sel  = 4'hf;
            b.we   = 1'b0;
            b.dat  = '0;
            b.is_d = is_d;
            b.last = (k == (quad ? `AWB_BURST_LEN - 1 : 0));
            exp_q.push_back(b);
        end
    endtask

    task automatic push_dreq(input dcache_req_t r);
        beat_t b;
        if (r.write)
        begin
            b.adr  = {r.addr[31:2], expected_offset(r.be)};
            b.sel  = r.be;
            b.we   = 1'b1;
            b.dat  = r.wdata;
            b.is_d = 1'b1;
            b.last = 1'b1;
            exp_q.push_back(b);
        end
        else
        begin
            push_read(1'b1, r.addr, r.qword);
        end
    endtask

    // strobes for one cycle, then waits for every expected ready pulse to come back
    task automatic issue(input logic do_i, input icache_req_t ir,
                         input logic do_d, input dcache_req_t dr);
        @(posedge clk);
        #1;
        started    = 1'b1;
        icache_req = do_i;
        icache     = ir;
        dcache_req = do_d;
        dcache     = dr;
        // the data cache wins, so its beats come first
        if (do_d)
        begin
            push_dreq(dr);
        end
        if (do_i)
        begin
            push_read(1'b0, ir.addr, ir.qword);
        end
        @(posedge clk);
        #1;
        icache_req = 1'b0;
        dcache_req = 1'b0;
        while (exp_q.size() != 0)
        begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
    endtask

    // ========================================
    // checks
    // ========================================

    a_idle: assert property (@(posedge clk) disable iff (!quick_n_reset)
        !started |-> (!wb_m2s.cyc && !wb_m2s.stb && !icache_ready && !dcache_ready))
        else stop_run("bus or ready active after reset before any request");

    // the slave may stall any number of cycles and must see one stable beat
    a_hold: assert property (@(posedge clk) disable iff (!quick_n_reset)
        (wb_m2s.stb && !wb_s2m.ack) |=>
            $stable({wb_m2s.adr, wb_m2s.sel, wb_m2s.we, wb_m2s.dat}))
        else stop_run("bus signals changed while stb waited for ack");

    a_ready_ack: assert property (@(posedge clk) disable iff (!quick_n_reset)
        (icache_ready || dcache_ready) |-> (wb_m2s.stb && wb_s2m.ack))
        else stop_run("ready pulse without a bus ack");

    // every ack is matched against the next queued beat and the reference memory
    always @(posedge clk)
    begin
        if (quick_n_reset)
        begin
            if (idle_chk)
            begin
                assert (!wb_m2s.cyc && !wb_m2s.stb)
                else stop_run("cyc or stb still high in the cycle after a final ack");
                idle_chk = 1'b0;
            end
            if (wb_m2s.stb && wb_s2m.ack)
            begin
                if (exp_q.size() == 0)
                begin
                    stop_run("ack arrived with no access expected");
                end
                else
                begin
                    beat = exp_q.pop_front();
                    assert (wb_m2s.adr == beat.adr)
                    else report_mismatch("o_wb.adr", wb_m2s.adr, beat.adr);
                    assert (wb_m2s.sel == beat.sel)
                    else report_mismatch("o_wb.sel", 32'(wb_m2s.sel), 32'(beat.sel));
                    assert (wb_m2s.we == beat.we)
                    else report_mismatch("o_wb.we", 32'(wb_m2s.we), 32'(beat.we));
                    assert (dcache_ready == beat.is_d)
                    else report_mismatch("o_dcache_ready", 32'(dcache_ready), 32'(beat.is_d));
                    assert (icache_ready == !beat.is_d)
                    else report_mismatch("o_icache_ready", 32'(icache_ready), 32'(!beat.is_d));
                    if (beat.we)
                    begin
                        assert (wb_m2s.dat == beat.dat)
                        else report_mismatch("o_wb.dat", wb_m2s.dat, beat.dat);
                        for (int k = 0; k < `AWB_SEL_W; k++)
                        begin
                            if (beat.sel[k])
                            begin
                                ref_mem[beat.adr[9:2]][8*k +: 8] = beat.dat[8*k +: 8];
                            end
                        end
                    end
                    else if (beat.is_d)
                    begin
                        assert (dcache_rdata == ref_mem[beat.adr[9:2]])
                        else report_mismatch("o_dcache_rdata", dcache_rdata,
                                             ref_mem[beat.adr[9:2]]);
                    end
                    else
                    begin
                        assert (icache_rdata == ref_mem[beat.adr[9:2]])
                        else report_mismatch("o_icache_rdata", icache_rdata,
                                             ref_mem[beat.adr[9:2]]);
                    end
                    idle_chk = beat.last;
                end
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_run("watchdog expired before all requests completed");
    end

    // ========================================
    // stimulus
    // ========================================

    initial
    begin
        logic [31:0] addr;
        logic [31:0] addr2;
        int          kind;
        quick_n_reset = 1'b0;
        icache_req    = 1'b0;
        icache        = '0;
        dcache_req    = 1'b0;
        dcache        = '0;
        started       = 1'b0;
        idle_chk      = 1'b0;
        be_list       = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                          4'b0011, 4'b1100, 4'b1111, 4'b0110};
        void'($urandom(32'hda91));
        for (int i = 0; i < 256; i++)
        begin
            ref_mem[i] = fill_word(i);
        end
        repeat (8) @(posedge clk);
        #1;
        quick_n_reset = 1'b1;
        // idle cycles give the reset assertion something to look at
        repeat (4) @(posedge clk);

        for (int i = 0; i < N_SINGLE; i++)
        begin
            issue(1'b1, mk_ireq(32'($urandom_range(0, 1023)), 1'b0), 1'b0, '0);
        end
        // line fills alternate between the two caches
        for (int i = 0; i < N_QUAD; i++)
        begin
            addr = 32'($urandom_range(0, 1023));
            if (i % 2 == 0)
            begin
                issue(1'b1, mk_ireq(addr, 1'b1), 1'b0, '0);
            end
            else
            begin
                issue(1'b0, '0, 1'b1, mk_dreq(addr, 1'b1, 1'b0, '0, 4'h0));
            end
        end
        // each write is read back to see the merged word
        for (int i = 0; i < N_WRITE; i++)
        begin
            addr = 32'($urandom_range(0, 1023));
            issue(1'b0, '0, 1'b1, mk_dreq(addr, 1'b0, 1'b1, $urandom(), be_list[i]));
            issue(1'b0, '0, 1'b1, mk_dreq(addr, 1'b0, 1'b0, '0, 4'h0));
        end

        // both caches strobe in the same cycle
        addr  = 32'($urandom_range(0, 1023));
        addr2 = 32'($urandom_range(0, 1023));
        issue(1'b1, mk_ireq(addr, 1'b1), 1'b1, mk_dreq(addr2, 1'b0, 1'b0, '0, 4'h0));
        issue(1'b1, mk_ireq(addr2, 1'b0), 1'b1, mk_dreq(addr, 1'b0, 1'b1, $urandom(), 4'b1100));

        for (int i = 0; i < N_RANDOM; i++)
        begin
            kind  = $urandom_range(0, 3);
            addr  = 32'($urandom_range(0, 1023));
            addr2 = 32'($urandom_range(0, 1023));
            case (kind)
                0: issue(1'b1, mk_ireq(addr, 1'($urandom())), 1'b0, '0);
                1: issue(1'b0, '0, 1'b1, mk_dreq(addr, 1'($urandom()), 1'b0, '0, 4'h0));
                2: issue(1'b0, '0, 1'b1,
                         mk_dreq(addr, 1'b0, 1'b1, $urandom(), 4'($urandom_range(1, 15))));
                default: issue(1'b1, mk_ireq(addr, 1'($urandom())), 1'b1,
                               mk_dreq(addr2, 1'($urandom()), 1'b0, '0, 4'h0));
            endcase
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// File: tb/wb_mem_model.sv
// wishbone slave memory of 256 words with random wait states, used by the master testbench

`timescale 1ns/1ps

`include "amber_wb_config.svh"

module wb_mem_model
    import wb_bus_pkg::*;
(
    input  logic    i_clk,
    input  logic    quick_n_reset,
    input  wb_m2s_t i_wb,
    output wb_s2m_t o_wb
);

    logic [`AWB_DATA_W-1:0] mem [0:255];
    // cycles still to wait before the next ack
    logic [1:0]             wait_r;
    logic                   ack_r;
    logic [`AWB_DATA_W-1:0] dat_r;
    logic [7:0]             idx_c;

    // word index, the upper address bits alias onto the same 256 words
    assign idx_c = i_wb.adr[9:2];

    always @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            ack_r  <= 1'b0;
            wait_r <= 2'($urandom_range(0, 3));
            // fill pattern mixes the whole word index
            for (int i = 0; i < 256; i++)
            begin
                mem[i] <= (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
            end
        end
        else
        begin
            ack_r <= 1'b0;
            // ack is registered so it never stays high two cycles in a row
            if (i_wb.cyc && i_wb.stb && !ack_r)
            begin
                if (wait_r != 2'd0)
                begin
                    wait_r <= wait_r - 2'd1;
                end
                else
                begin
                    ack_r  <= 1'b1;
                    dat_r  <= mem[idx_c];
                    wait_r <= 2'($urandom_range(0, 3));
                    // writes merge lane by lane under sel
                    if (i_wb.we)
                    begin
                        for (int b = 0; b < `AWB_SEL_W; b++)
                        begin
                            if (i_wb.sel[b])
                            begin
                                mem[idx_c][8*b +: 8] <= i_wb.dat[8*b +: 8];
                            end
                        end
                    end
                end
            end
        end
    end

    always_comb
    begin
        o_wb.dat = dat_r;
        o_wb.ack = ack_r;
    end

endmodule
